//--- verilog.f
+incdir+common
common/lrelu_pkg.sv
src/axis_reg_slice.sv
lrelu/lrelu_config_regs.sv
lrelu/lrelu_width_converter.sv
lrelu/lrelu_datapath.sv
lrelu/axis_lrelu_engine.sv
dv/lrelu_engine_properties.sv
dv/axis_lrelu_engine_tb.sv

//--- Makefile
TOP = axis_lrelu_engine_tb

.PHONY: sim clean

sim:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) -f verilog.f -o $(TOP)
	./obj_dir/$(TOP)

clean:
	rm -rf obj_dir

//--- dv/axis_lrelu_engine_tb.sv
`timescale 1ns/10ps
`default_nettype none
`include "lrelu_defines.svh"

module axis_lrelu_engine_tb;
    import lrelu_pkg::*;

    localparam int MEMBERS = `LRELU_MEMBERS;
    localparam int LANES   = `LRELU_LANES;
    localparam int OUT_W   = `LRELU_WIDTH_OUT;
    localparam int ACC_W   = `LRELU_WIDTH_ACC;
    localparam int SCALE_W = `LRELU_WIDTH_SCALE;
    localparam int BIAS_W  = `LRELU_WIDTH_BIAS;
    localparam int ACC_MAX = 2**(ACC_W-1) - 1;
    localparam int ACC_MIN = -(2**(ACC_W-1));
    localparam int OUT_MAX = 2**(OUT_W-1) - 1;
    localparam int OUT_MIN = -(2**(OUT_W-1));
    localparam int TIMEOUT = 5000;         // cycles allowed for any one wait
    localparam int SEED    = 32'h0caf261e;

    logic                   aclk, reset, s_tvalid, s_tready, s_tlast;
    logic                   m_tvalid, m_tready, m_tlast;
    lrelu_beat_u            s_tdata;
    logic [LANES*OUT_W-1:0] m_tdata;

    integer data_seed, ready_seed;
    int     stall_pct  = 0;  // chance of m_tready low, percent
    int     gap_pct    = 0;  // chance of an idle gap before a beat
    int     word_count = 0;  // words seen in the current output frame

    logic [SCALE_W-1:0]     cfg_scale [MEMBERS][LANES];
    logic [BIAS_W-1:0]      cfg_bias  [MEMBERS][LANES];
    lrelu_beat_u            frame_beats [$];
    logic [LANES*OUT_W-1:0] exp_data [$];
    int                     frame_words [$];
    logic [LANES*OUT_W-1:0] want_data;
    logic                   want_last;

    axis_lrelu_engine UUT (.*);

    bind axis_lrelu_engine lrelu_engine_properties props (
        .aclk     (aclk),
        .reset    (reset),
        .s_tready (s_tready),
        .m_tvalid (m_tvalid),
        .m_tready (m_tready),
        .m_tdata  (m_tdata),
        .m_tlast  (m_tlast)
    );

    initial begin
        aclk = 1'b0;
        forever #4 aclk = ~aclk;
    end

    task automatic abort_run(input string msg);
        $display("%s", msg);
        $display("** FAIL **");
        $fatal(1, "simulation stopped");
    endtask

    // multiply, add bias, requant shift, leak negatives, clamp
    function automatic logic [OUT_W-1:0] lrelu_ref(
        input logic [ACC_W-1:0]   acc,
        input logic [SCALE_W-1:0] scale,
        input logic [BIAS_W-1:0]  bias
    );
        longint v;
        v = longint'($signed(acc)) * longint'(scale) + longint'($signed(bias));
        v = v >>> `LRELU_SHIFT;
        if (v < 0)
            v = v >>> `LRELU_ALPHA_SHIFT;
        if (v > OUT_MAX)
            v = OUT_MAX;
        else if (v < OUT_MIN)
            v = OUT_MIN;
        return v[OUT_W-1:0];
    endfunction

    function automatic int rand_range(input int lo, input int hi);
        return lo + int'($unsigned($random(data_seed)) % (hi - lo + 1));
    endfunction

    task automatic randomize_config();
        for (int m = 0; m < MEMBERS; m++) begin
            for (int l = 0; l < LANES; l++) begin
                cfg_scale[m][l] = SCALE_W'(rand_range(0, 63));
                cfg_bias[m][l]  = BIAS_W'(rand_range(-4096, 4095));
            end
        end
    endtask

    task automatic queue_random_frame(input int n_beats);
        lrelu_beat_u beat;
        frame_beats.delete();
        for (int b = 0; b < n_beats; b++) begin
            for (int m = 0; m < MEMBERS; m++) begin
                for (int l = 0; l < LANES; l++) begin
                    if (rand_range(0, 7) == 0)  // full scale now and then
                        beat.data[m][l] = ACC_W'(rand_range(ACC_MIN, ACC_MAX));
                    else
                        beat.data[m][l] = ACC_W'(rand_range(-2048, 2047));
                end
            end
            frame_beats.push_back(beat);
        end
    endtask

    // returns at the edge where the beat was taken
    task automatic send_beat(input lrelu_beat_u beat, input logic last);
        int waited;
        waited = 0;
        if (rand_range(0, 99) < gap_pct) begin
            @(negedge aclk);
            s_tvalid = 1'b0;
            repeat (rand_range(0, 2)) @(negedge aclk);
        end
        @(negedge aclk);
        s_tvalid = 1'b1;
        s_tdata  = beat;
        s_tlast  = last;
        @(posedge aclk);
        while (!s_tready) begin
            if (waited == TIMEOUT)
                abort_run("input beat was never accepted, s_tready stayed low");
            waited++;
            @(posedge aclk);
        end
    endtask

    task automatic stop_input();
        @(negedge aclk);
        s_tvalid = 1'b0;
        s_tlast  = 1'b0;
    endtask

    // config beats, then the queued data beats with their expected words
    task automatic send_frame();
        lrelu_beat_u            cfg_beat;
        logic [LANES*OUT_W-1:0] w;
        int                     n;
        n = frame_beats.size();
        for (int m = 0; m < MEMBERS; m++) begin
            cfg_beat = '0;
            for (int l = 0; l < LANES; l++) begin
                cfg_beat.cfg.scale[l] = cfg_scale[m][l];
                cfg_beat.cfg.bias[l]  = cfg_bias[m][l];
            end
            send_beat(cfg_beat, 1'b0);
        end
        frame_words.push_back(n * MEMBERS);
        for (int b = 0; b < n; b++) begin
            for (int m = 0; m < MEMBERS; m++) begin
                for (int l = 0; l < LANES; l++)
                    w[l*OUT_W +: OUT_W] = lrelu_ref(frame_beats[b].data[m][l],
                                                    cfg_scale[m][l], cfg_bias[m][l]);
                exp_data.push_back(w);
            end
            send_beat(frame_beats[b], b == n - 1);
        end
    endtask

    task automatic wait_drained();
        int waited;
        waited = 0;
        while (exp_data.size() != 0) begin
            if (waited == TIMEOUT)
                abort_run("output words still missing after the drain timeout");
            waited++;
            @(negedge aclk);
        end
    endtask

    initial begin
        ready_seed = SEED ^ 32'h5a5a5a5a;  // own stream, independent of stimulus order
        m_tready   = 1'b1;
        forever begin
            @(negedge aclk);
            m_tready = ($unsigned($random(ready_seed)) % 100) >= stall_pct;
        end
    end

    // scoreboard on every output transfer
    always @(posedge aclk) begin
        if (!reset && m_tvalid && m_tready) begin
            if (exp_data.size() == 0) begin
                abort_run("the DUT sent an output word that was not expected");
            end else begin
                want_data = exp_data.pop_front();
                word_count++;
                want_last = (word_count == frame_words[0]);  // last member of the tlast beat
                assert (m_tdata == want_data && m_tlast == want_last) else
                    abort_run($sformatf("ERR %0t: m_tdata/m_tlast expected %h/%b got %h/%b",
                                        $time, want_data, want_last, m_tdata, m_tlast));
                if (want_last) begin
                    frame_words.delete(0);
                    word_count = 0;
                end
            end
        end
    end

    initial begin
        lrelu_beat_u edge_beat;
        data_seed = SEED;
        reset     = 1'b1;
        s_tvalid  = 1'b0;
        s_tlast   = 1'b0;
        s_tdata   = '0;
        repeat (8) @(posedge aclk);
        @(negedge aclk);
        reset = 1'b0;
        assert (!m_tvalid && s_tready) else
            abort_run($sformatf("ERR %0t: after reset m_tvalid %b s_tready %b",
                                $time, m_tvalid, s_tready));

        // single frame, then back to back frames with new config each time
        repeat (4) begin
            randomize_config();
            queue_random_frame(rand_range(3, 12));
            send_frame();
        end

        // saturation at both ends and leaked small negatives
        assert (lrelu_ref(ACC_W'(ACC_MAX), 255, 0) == 8'h7f
                && lrelu_ref(ACC_W'(ACC_MIN), 255, 0) == 8'h80
                && lrelu_ref(ACC_W'(-1600), 1, 0) == 8'hfc) else
            abort_run($sformatf("ERR %0t: reference model edge values wrong", $time));
        frame_beats.delete();
        for (int l = 0; l < LANES; l++) begin
            cfg_scale[0][l] = 8'd255;
            cfg_bias[0][l]  = '0;
            cfg_scale[1][l] = 8'd1;
            cfg_bias[1][l]  = '0;
        end
        for (int b = 0; b < 3; b++) begin
            for (int l = 0; l < LANES; l++) begin
                edge_beat.data[0][l] = ((l + b) % 2 == 0) ? ACC_W'(ACC_MAX) : ACC_W'(ACC_MIN);
                edge_beat.data[1][l] = ACC_W'(-1600 * (l + 1 + b));
            end
            frame_beats.push_back(edge_beat);
        end
        send_frame();

        // back-pressure and input gaps
        stall_pct = 40;
        gap_pct   = 30;
        repeat (4) begin
            randomize_config();
            queue_random_frame(rand_range(3, 12));
            send_frame();
        end
        stop_input();
        wait_drained();
        repeat (8) @(negedge aclk);  // room for any stray extra word

        if (!m_tvalid) begin
            $display("** PASS **");
            $finish;
        end else begin
            abort_run("an output word is still waiting after the last frame");
        end
    end

endmodule

`default_nettype wire

//--- dv/lrelu_engine_properties.sv
`timescale 1ns/10ps
`default_nettype none
`include "lrelu_defines.svh"

module lrelu_engine_properties (
    input logic                                     aclk,
    input logic                                     reset,
    input logic                                     s_tready,
    input logic                                     m_tvalid,
    input logic                                     m_tready,
    input logic [`LRELU_LANES*`LRELU_WIDTH_OUT-1:0] m_tdata,
    input logic                                     m_tlast
);

    // a stalled word keeps data and last until it is taken
    hold_on_stall: assert property (
        @(posedge aclk) disable iff (reset)
        m_tvalid && !m_tready |=> m_tvalid && $stable(m_tdata) && $stable(m_tlast)
    ) else $error("output word changed or vanished while stalled");

    // nothing leaves while reset is held
    quiet_in_reset: assert property (@(posedge aclk) reset |=> !m_tvalid)
        else $error("m_tvalid high after a reset cycle");

    ready_after_reset: assert property (@(posedge aclk) $fell(reset) |-> s_tready)
        else $error("s_tready low when reset was released");  // CONFIG takes beats

endmodule

`default_nettype wire

//--- lrelu/axis_lrelu_engine.sv
`timescale 1ns/10ps
`default_nettype none
`include "lrelu_defines.svh"

module axis_lrelu_engine (
    input  logic                                    aclk,
    input  logic                                    reset,
    input  logic                                    s_tvalid,
    output logic                                    s_tready,
    input  lrelu_pkg::lrelu_beat_u                  s_tdata,
    input  logic                                    s_tlast,
    output logic                                    m_tvalid,
    input  logic                                    m_tready,
    output logic [`LRELU_LANES*`LRELU_WIDTH_OUT-1:0] m_tdata,
    output logic                                    m_tlast
);
    import lrelu_pkg::*;

    localparam logic [0:0] MEMBER_LAST = 1'(`LRELU_MEMBERS - 1);

    typedef enum logic [1:0] {
        CONFIG,  // config beats go to the register block
        PASS,    // data beats go to the width converter
        DRAIN    // input held until the tlast beat leaves the converter
    } state_t;

    state_t           state, state_next;
    logic [0:0]       cfg_count;     // which member the next config beat is for
    logic             cfg_we;
    logic             conv_in_valid, conv_in_ready;
    logic             conv_out_valid, conv_out_last;
    logic [0:0]       conv_out_member;
    lrelu_lane_word_t conv_out_word;
    logic             enable;        // slice can take a word, whole pipe moves

    logic [`LRELU_LANES-1:0][`LRELU_WIDTH_SCALE-1:0] scale;
    logic [`LRELU_LANES-1:0][`LRELU_WIDTH_BIAS-1:0]  bias;

    logic                                    dp_valid, dp_last;
    logic [`LRELU_LANES*`LRELU_WIDTH_OUT-1:0] dp_data;

    assign cfg_we = (state == CONFIG) && s_tvalid;  // s_tready is high in CONFIG

    always_comb begin
        state_next    = state;
        s_tready      = 1'b0;
        conv_in_valid = 1'b0;
        case (state)
            CONFIG: begin
                s_tready = 1'b1;
                if (s_tvalid && cfg_count == MEMBER_LAST)
                    state_next = PASS;
            end
            PASS: begin
                conv_in_valid = s_tvalid;
                s_tready      = conv_in_ready;
                if (s_tvalid && conv_in_ready && s_tlast)
                    state_next = DRAIN;
            end
            DRAIN: begin
                // last member of the frame is leaving, safe to take new config
                if (conv_out_valid && conv_out_last && enable)
                    state_next = CONFIG;
            end
            default: state_next = CONFIG;
        endcase
    end

    always_ff @(posedge aclk) begin
        if (reset) begin
            state     <= CONFIG;
            cfg_count <= '0;
        end else begin
            state <= state_next;
            if (cfg_we)
                cfg_count <= (cfg_count == MEMBER_LAST) ? '0 : cfg_count + 1'b1;
        end
    end

    lrelu_config_regs cfg_regs (
        .aclk       (aclk),
        .reset      (reset),
        .cfg_we     (cfg_we),
        .cfg_member (cfg_count),
        .cfg_beat   (s_tdata),
        .rd_member  (conv_out_member),
        .scale      (scale),
        .bias       (bias)
    );

    lrelu_width_converter dw (
        .aclk       (aclk),
        .reset      (reset),
        .in_valid   (conv_in_valid),
        .in_ready   (conv_in_ready),
        .in_beat    (s_tdata),
        .in_last    (s_tlast),
        .enable     (enable),
        .out_valid  (conv_out_valid),
        .out_word   (conv_out_word),
        .out_member (conv_out_member),
        .out_last   (conv_out_last)
    );

    lrelu_datapath engine (
        .aclk      (aclk),
        .reset     (reset),
        .enable    (enable),
        .in_valid  (conv_out_valid),
        .in_word   (conv_out_word),
        .in_last   (conv_out_last),
        .scale     (scale),
        .bias      (bias),
        .out_valid (dp_valid),
        .out_data  (dp_data),
        .out_last  (dp_last)
    );

    axis_reg_slice #(
        .WIDTH (`LRELU_LANES*`LRELU_WIDTH_OUT)
    ) slice (
        .aclk    (aclk),
        .reset   (reset),
        .s_valid (dp_valid),
        .s_ready (enable),
        .s_data  (dp_data),
        .s_last  (dp_last),
        .m_valid (m_tvalid),
        .m_ready (m_tready),
        .m_data  (m_tdata),
        .m_last  (m_tlast)
    );

endmodule

`default_nettype wire

//--- lrelu/lrelu_datapath.sv
`timescale 1ns/10ps
`default_nettype none
`include "lrelu_defines.svh"

module lrelu_datapath (
    input  logic                                    aclk,
    input  logic                                    reset,
    input  logic                                    enable,
    input  logic                                    in_valid,
    input  lrelu_pkg::lrelu_lane_word_t             in_word,
    input  logic                                    in_last,
    input  logic [`LRELU_LANES-1:0][`LRELU_WIDTH_SCALE-1:0] scale,
    input  logic [`LRELU_LANES-1:0][`LRELU_WIDTH_BIAS-1:0]  bias,
    output logic                                    out_valid,
    output logic [`LRELU_LANES*`LRELU_WIDTH_OUT-1:0] out_data,
    output logic                                    out_last
);

    // product of acc and zero-extended scale, plus one bit for the bias add
    localparam int WIDTH_MAC = `LRELU_WIDTH_ACC + `LRELU_WIDTH_SCALE + 2;
    localparam int OUT_MAX   = 2**(`LRELU_WIDTH_OUT-1) - 1;
    localparam int OUT_MIN   = -(2**(`LRELU_WIDTH_OUT-1));

    logic signed [WIDTH_MAC-1:0] mac   [`LRELU_LANES];
    logic signed [WIDTH_MAC-1:0] mac_q [`LRELU_LANES];  // stage 1
    logic                        valid_q, last_q;
    logic [`LRELU_LANES-1:0][`LRELU_WIDTH_OUT-1:0] sat;

    // shift, leak the negatives, clamp to the output range
    function automatic logic [`LRELU_WIDTH_OUT-1:0] requant(
        input logic signed [WIDTH_MAC-1:0] v
    );
        logic signed [WIDTH_MAC-1:0] s;
        s = v >>> `LRELU_SHIFT;
        if (s < 0)
            s = s >>> `LRELU_ALPHA_SHIFT;
        if (s > OUT_MAX)
            s = WIDTH_MAC'(OUT_MAX);
        else if (s < OUT_MIN)
            s = WIDTH_MAC'(OUT_MIN);
        return s[`LRELU_WIDTH_OUT-1:0];
    endfunction

    always_comb begin
        for (int l = 0; l < `LRELU_LANES; l++) begin
            mac[l] = $signed(in_word[l]) * $signed({1'b0, scale[l]}) + $signed(bias[l]);
            sat[l] = requant(mac_q[l]);
        end
    end

    always_ff @(posedge aclk) begin
        if (reset) begin
            valid_q   <= 1'b0;
            out_valid <= 1'b0;
        end else if (enable) begin
            valid_q   <= in_valid;
            out_valid <= valid_q;
        end
    end

    // config is already folded in here, later rewrites do not touch it
    always_ff @(posedge aclk) begin
        if (enable) begin
            for (int l = 0; l < `LRELU_LANES; l++)
                mac_q[l] <= mac[l];
            last_q   <= in_last;
            out_data <= sat;    // stage 2
            out_last <= last_q;
        end
    end

endmodule

`default_nettype wire

//--- lrelu/lrelu_width_converter.sv
`timescale 1ns/10ps
`default_nettype none
`include "lrelu_defines.svh"

module lrelu_width_converter (
    input  logic                        aclk,
    input  logic                        reset,
    input  logic                        in_valid,
    output logic                        in_ready,
    input  lrelu_pkg::lrelu_beat_u      in_beat,
    input  logic                        in_last,
    input  logic                        enable,
    output logic                        out_valid,
    output lrelu_pkg::lrelu_lane_word_t out_word,
    output logic [0:0]                  out_member,
    output logic                        out_last
);
    import lrelu_pkg::*;

    localparam logic [0:0] MEMBER_LAST = 1'(`LRELU_MEMBERS - 1);

    lrelu_beat_u beat_q;       // beat being split
    logic        beat_last_q;  // beat came with tlast
    logic        valid_q;
    logic [0:0]  member_q;     // member currently presented
    logic        final_member;
    logic        accept;

    assign final_member = (member_q == MEMBER_LAST);

    // empty, or the final member leaves this cycle
    assign in_ready = !valid_q || (enable && final_member);
    assign accept   = in_valid && in_ready;

    always_ff @(posedge aclk) begin
        if (reset) begin
            valid_q  <= 1'b0;
            member_q <= '0;
        end else if (accept) begin
            valid_q  <= 1'b1;
            member_q <= '0;  // member 0 goes out first
        end else if (enable && valid_q) begin
            if (final_member)
                valid_q <= 1'b0;
            else
                member_q <= member_q + 1'b1;
        end
    end

    always_ff @(posedge aclk) begin
        if (accept) begin
            beat_q      <= in_beat;
            beat_last_q <= in_last;
        end
    end

    assign out_valid  = valid_q;
    assign out_word   = beat_q.data[member_q];
    assign out_member = member_q;
    assign out_last   = valid_q && beat_last_q && final_member;

endmodule

`default_nettype wire

//--- lrelu/lrelu_config_regs.sv
`timescale 1ns/10ps
`default_nettype none
`include "lrelu_defines.svh"

module lrelu_config_regs (
    input  logic                                    aclk,
    input  logic                                    reset,
    input  logic                                    cfg_we,
    input  logic [0:0]                              cfg_member,
    input  lrelu_pkg::lrelu_beat_u                  cfg_beat,
    input  logic [0:0]                              rd_member,
    output logic [`LRELU_LANES-1:0][`LRELU_WIDTH_SCALE-1:0] scale,
    output logic [`LRELU_LANES-1:0][`LRELU_WIDTH_BIAS-1:0]  bias
);

    // one scale and bias set per member
    logic [`LRELU_LANES-1:0][`LRELU_WIDTH_SCALE-1:0] scale_q [`LRELU_MEMBERS];
    logic [`LRELU_LANES-1:0][`LRELU_WIDTH_BIAS-1:0]  bias_q  [`LRELU_MEMBERS];

    always_ff @(posedge aclk) begin
        if (reset) begin
            for (int m = 0; m < `LRELU_MEMBERS; m++) begin
                scale_q[m] <= '0;
                bias_q[m]  <= '0;
            end
        end else if (cfg_we) begin
            // config view of the beat, lane l of the set for cfg_member
            scale_q[cfg_member] <= cfg_beat.cfg.scale;
            bias_q[cfg_member]  <= cfg_beat.cfg.bias;
        end
    end

    // read side follows the member the converter presents
    assign scale = scale_q[rd_member];
    assign bias  = bias_q[rd_member];

endmodule

`default_nettype wire

//--- src/axis_reg_slice.sv
`timescale 1ns/10ps
`default_nettype none

module axis_reg_slice #(
    parameter int WIDTH = 32
) (
    input  logic             aclk,
    input  logic             reset,
    input  logic             s_valid,
    output logic             s_ready,
    input  logic [WIDTH-1:0] s_data,
    input  logic             s_last,
    output logic             m_valid,
    input  logic             m_ready,
    output logic [WIDTH-1:0] m_data,
    output logic             m_last
);

    logic             skid_valid;  // second entry holds a word
    logic [WIDTH-1:0] skid_data;
    logic             skid_last;
    logic             main_free;   // main entry empty or leaving

    assign s_ready   = !skid_valid;  // straight from a flop, no path from m_ready
    assign main_free = m_ready || !m_valid;

    always_ff @(posedge aclk) begin
        if (reset) begin
            m_valid    <= 1'b0;
            skid_valid <= 1'b0;
        end else if (!skid_valid) begin
            if (main_free)
                m_valid <= s_valid;
            else if (s_valid)
                skid_valid <= 1'b1;  // stalled, park the word
        end else if (m_ready) begin
            skid_valid <= 1'b0;      // skid moves up, m_valid stays high
        end
    end

    always_ff @(posedge aclk) begin
        if (!skid_valid) begin
            if (main_free) begin
                m_data <= s_data;
                m_last <= s_last;
            end else begin
                skid_data <= s_data;
                skid_last <= s_last;
            end
        end else if (m_ready) begin
            m_data <= skid_data;
            m_last <= skid_last;
        end
    end

endmodule

`default_nettype wire

//--- common/lrelu_pkg.sv
`default_nettype none
`include "lrelu_defines.svh"

package lrelu_pkg;

    // one accumulator word for each lane of a member
    typedef logic [`LRELU_LANES-1:0][`LRELU_WIDTH_ACC-1:0] lrelu_lane_word_t;

    // config beat layout, scale and bias per lane, upper bits unused
    typedef struct packed {
        logic [`LRELU_MEMBERS*`LRELU_LANES*`LRELU_WIDTH_ACC
               - `LRELU_LANES*(`LRELU_WIDTH_SCALE+`LRELU_WIDTH_BIAS)-1:0] pad;
        logic [`LRELU_LANES-1:0][`LRELU_WIDTH_SCALE-1:0]                  scale;
        logic [`LRELU_LANES-1:0][`LRELU_WIDTH_BIAS-1:0]                   bias;
    } lrelu_cfg_t;

    // same input word seen as data (member 0 in the low bits) or as config
    typedef union packed {
        lrelu_lane_word_t [`LRELU_MEMBERS-1:0] data;
        lrelu_cfg_t                            cfg;
    } lrelu_beat_u;

endpackage

`default_nettype wire

//--- common/lrelu_defines.svh
`ifndef LRELU_DEFINES_SVH
`define LRELU_DEFINES_SVH

// lanes in one member word
`define LRELU_LANES 4

// member words packed into one input beat
`define LRELU_MEMBERS 2

// word widths, acc and out are signed, scale is unsigned
`define LRELU_WIDTH_ACC 20
`define LRELU_WIDTH_OUT 8
`define LRELU_WIDTH_SCALE 8
`define LRELU_WIDTH_BIAS 16

// requantization right shift after the multiply-add
`define LRELU_SHIFT 6

// leak for negative values, divides by 8
`define LRELU_ALPHA_SHIFT 3

`endif
